// ==== include/exe_macros.svh ====
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Datapath width of the execute unit
`define XLEN 32

// One iteration per quotient bit
`define DIV_STEPS 32
`define DIV_CNT_W 6  // Holds 0 to DIV_STEPS

`endif

// ==== src/exe_pkg.sv ====
package exe_pkg;

	// Operation select, ALU group first then RV32M divide group
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SRA  = 4'd7,
		OP_SLT  = 4'd8,
		OP_SLTU = 4'd9,
		OP_DIV  = 4'd10,
		OP_DIVU = 4'd11,
		OP_REM  = 4'd12,
		OP_REMU = 4'd13
	} exe_op_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,  // Load cycle, steps, drain cycle
		DONE = 2'd2   // Finish cycle
	} div_state_t;

	function automatic logic is_div_op(exe_op_t op);
		return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
	endfunction

endpackage

// ==== src/div_ctrl_if.sv ====
`include "exe_macros.svh"

// Divider control and result bundle
interface div_ctrl_if;

	logic load;                  // Latch operands, clear step count
	logic step;                  // One shift-subtract per cycle
	logic last;                  // Final step in progress
	logic finish;                // Correction cycle
	logic [`XLEN-1:0] result;    // Corrected quotient or remainder

	// State machine side
	modport fsm (output load, output step, output finish, input last);

	// Iteration counter
	modport counter (input load, input step, output last);

	// Arithmetic
	modport datapath (input load, input step, input finish, output result);

endinterface

// ==== src/div_fsm.sv ====
module div_fsm import exe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input exe_op_t op,
	output logic busy,
	div_ctrl_if.fsm ctl
);

	div_state_t state_q;
	logic step_q;  // Held from start until the last step

	// Divide accepted only from IDLE
	assign ctl.load = (state_q == IDLE) && issue && is_div_op(op);
	assign ctl.step = step_q;
	assign ctl.finish = (state_q == DONE);

	assign busy = (state_q != IDLE);  // Covers RUN and DONE

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
			step_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (ctl.load) begin
						state_q <= RUN;
						step_q <= 1'b1;  // Steps start next edge
					end
				end
				RUN: begin
					// One drain cycle after the final step
					if (!step_q) begin
						state_q <= DONE;
					end else if (ctl.last) begin
						step_q <= 1'b0;
					end
				end
				DONE: begin
					state_q <= IDLE;  // Result taken by the output stage
				end
				default: begin
					state_q <= IDLE;
					step_q <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== src/div_step_counter.sv ====
`include "exe_macros.svh"

module div_step_counter (
	input logic clk,
	input logic rst_n,
	div_ctrl_if.counter ctl
);

	// Final count value during the last step
	localparam logic [`DIV_CNT_W-1:0] LAST_CNT = `DIV_CNT_W'(`DIV_STEPS - 1);

	logic [`DIV_CNT_W-1:0] cnt_q;  // Steps done so far

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (ctl.load) begin
			cnt_q <= '0;  // New division
		end else if (ctl.step) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Count reaches DIV_STEPS after the last step and holds there
	assign ctl.last = ctl.step && (cnt_q == LAST_CNT);

endmodule

// ==== src/div_datapath.sv ====
`include "exe_macros.svh"

module div_datapath import exe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input exe_op_t op,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] op_b,
	div_ctrl_if.datapath ctl
);

	localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

	logic is_signed;
	logic [`XLEN-1:0] mag_a;
	logic [`XLEN-1:0] mag_b;

	logic [`XLEN-1:0] dividend_q;   // Raw dividend for special results
	logic [`XLEN-1:0] divisor_q;    // Divisor magnitude
	logic [`XLEN-1:0] quo_q;        // Dividend shifts out, quotient shifts in
	logic [`XLEN-1:0] rem_q;        // Partial remainder
	logic neg_quo_q;
	logic neg_rem_q;
	logic rem_sel_q;
	logic div_zero_q;
	logic ovf_q;

	logic [`XLEN:0] shifted;
	logic [`XLEN:0] diff;
	logic [`XLEN-1:0] quo_fix;
	logic [`XLEN-1:0] rem_fix;
	logic [`XLEN-1:0] final_val;

	assign is_signed = (op == OP_DIV) || (op == OP_REM);

	// Operand magnitudes, two's complement for negative signed inputs
	assign mag_a = (is_signed && op_a[`XLEN-1]) ? -op_a : op_a;
	assign mag_b = (is_signed && op_b[`XLEN-1]) ? -op_b : op_b;

	// Trial subtract, sign bit set means restore
	assign shifted = {rem_q, quo_q[`XLEN-1]};
	assign diff = shifted - {1'b0, divisor_q};

	always_ff @(posedge clk) begin
		if (ctl.load) begin
			dividend_q <= op_a;
			divisor_q <= mag_b;
			quo_q <= mag_a;
			rem_q <= '0;
		end else if (ctl.step) begin
			if (!diff[`XLEN]) begin
				rem_q <= diff[`XLEN-1:0];
				quo_q <= {quo_q[`XLEN-2:0], 1'b1};
			end else begin
				rem_q <= shifted[`XLEN-1:0];  // Restore
				quo_q <= {quo_q[`XLEN-2:0], 1'b0};
			end
		end
	end

	// Sign and special-case flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			neg_quo_q <= 1'b0;
			neg_rem_q <= 1'b0;
			rem_sel_q <= 1'b0;
			div_zero_q <= 1'b0;
			ovf_q <= 1'b0;
		end else if (ctl.load) begin
			neg_quo_q <= is_signed && (op_a[`XLEN-1] ^ op_b[`XLEN-1]);
			neg_rem_q <= is_signed && op_a[`XLEN-1];  // Remainder follows dividend
			rem_sel_q <= (op == OP_REM) || (op == OP_REMU);
			div_zero_q <= (op_b == '0);
			ovf_q <= is_signed && (op_a == MIN_NEG) && (op_b == '1);
		end
	end

	assign quo_fix = neg_quo_q ? -quo_q : quo_q;
	assign rem_fix = neg_rem_q ? -rem_q : rem_q;

	always_comb begin
		if (div_zero_q) begin
			final_val = rem_sel_q ? dividend_q : '1;  // All ones quotient
		end else if (ovf_q) begin
			final_val = rem_sel_q ? '0 : dividend_q;
		end else begin
			final_val = rem_sel_q ? rem_fix : quo_fix;
		end
	end

	assign ctl.result = ctl.finish ? final_val : '0;  // Valid in finish cycle only

endmodule

// ==== src/alu.sv ====
`include "exe_macros.svh"

module alu import exe_pkg::*; (
	input exe_op_t op,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] op_b,
	output logic [`XLEN-1:0] alu_result
);

	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = op_b[4:0];  // RV32 shift amount
	assign lt_signed = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		case (op)
			OP_ADD:  alu_result = op_a + op_b;
			OP_SUB:  alu_result = op_a - op_b;
			OP_AND:  alu_result = op_a & op_b;
			OP_OR:   alu_result = op_a | op_b;
			OP_XOR:  alu_result = op_a ^ op_b;
			OP_SLL:  alu_result = op_a << shamt;
			OP_SRL:  alu_result = op_a >> shamt;
			OP_SRA:  alu_result = $signed(op_a) >>> shamt;  // Sign fill
			OP_SLT:  alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
			OP_SLTU: alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			default: alu_result = '0;  // Divide ops handled elsewhere
		endcase
	end

endmodule

// ==== src/result_stage.sv ====
`include "exe_macros.svh"

module result_stage import exe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input exe_op_t op,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] op_b,
	input logic busy,
	input logic div_finish,
	input logic [`XLEN-1:0] div_result,
	output logic [`XLEN-1:0] result,
	output logic result_valid
);

	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] alu_hold_q;  // ALU result waiting for the output edge
	logic alu_accept;
	logic alu_pend_q;              // ALU result due at the next edge

	alu alu_i (
		.op(op),
		.op_a(op_a),
		.op_b(op_b),
		.alu_result(alu_result)
	);

	// ALU ops only while the divider is idle
	assign alu_accept = issue && !busy && !is_div_op(op);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_hold_q <= '0;
			alu_pend_q <= 1'b0;
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			alu_pend_q <= alu_accept;
			if (alu_accept) begin
				alu_hold_q <= alu_result;
			end
			result_valid <= alu_pend_q || div_finish;  // One cycle per result
			// Finish only in DONE, so never together with a pending ALU result
			if (div_finish) begin
				result <= div_result;
			end else if (alu_pend_q) begin
				result <= alu_hold_q;
			end
		end
	end

endmodule

// ==== src/execute_unit.sv ====
`include "exe_macros.svh"

module execute_unit import exe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input exe_op_t op,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] op_b,
	output logic [`XLEN-1:0] result,
	output logic result_valid,
	output logic busy
);

	div_ctrl_if div_ctrl ();  // Divider control bundle

	div_fsm div_fsm_i (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.op(op),
		.busy(busy),
		.ctl(div_ctrl.fsm)
	);

	div_step_counter div_step_counter_i (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(div_ctrl.counter)
	);

	div_datapath div_datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.op(op),
		.op_a(op_a),
		.op_b(op_b),
		.ctl(div_ctrl.datapath)
	);

	// Finish doubles as the divider capture strobe
	result_stage result_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.op(op),
		.op_a(op_a),
		.op_b(op_b),
		.busy(busy),
		.div_finish(div_ctrl.finish),
		.div_result(div_ctrl.result),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

// ==== sim/execute_unit_properties.sv ====
module execute_unit_properties import exe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input exe_op_t op,
	input logic result_valid,
	input logic busy
);

	logic div_accept;
	int unsigned fail_cnt = 0;  // Failed assertions so far

	assign div_accept = issue && !busy && (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});

	// One cycle per result
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid)
		else begin
			fail_cnt++;
			$error("result_valid held for more than one cycle");
		end

	a_busy_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(busy && result_valid))
		else begin
			fail_cnt++;
			$error("busy and result_valid high together");
		end

	// Accept at edge k, capture at edge k+34, seen at the next sample
	a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(div_accept, 35) |-> result_valid)
		else begin
			fail_cnt++;
			$error("divide result missing 34 cycles after issue");
		end

endmodule

bind execute_unit execute_unit_properties execute_unit_properties_i (
	.clk(clk),
	.rst_n(rst_n),
	.issue(issue),
	.op(op),
	.result_valid(result_valid),
	.busy(busy)
);

// ==== sim/execute_unit_tb.sv ====
`include "exe_macros.svh"

module execute_unit_tb import exe_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_FIXED = 8;
	localparam int N_RAND = 28;  // Two rows per operation
	localparam int N_ROWS = N_FIXED + N_RAND;
	localparam int ROW_LIMIT = 60;  // Cycles a row may wait for its result

	typedef struct packed {
		exe_op_t op;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] exp;
	} row_t;

	// Directed corner cases
	localparam row_t FIXED [N_FIXED] = '{
		'{OP_SRA, 32'hfffffff0, 32'h00000002, 32'hfffffffc},
		'{OP_SLT, 32'hffffffff, 32'h00000001, 32'h00000001},  // -1 below 1 when signed
		'{OP_SLTU, 32'hffffffff, 32'h00000001, 32'h00000000},
		'{OP_DIVU, 32'h00000064, 32'h00000000, 32'hffffffff},  // Zero divisor
		'{OP_REM, 32'hfffffff9, 32'h00000000, 32'hfffffff9},
		'{OP_DIV, 32'h80000000, 32'hffffffff, 32'h80000000},  // Signed overflow
		'{OP_REM, 32'h80000000, 32'hffffffff, 32'h00000000},
		'{OP_DIVU, 32'h000003e8, 32'h00000007, 32'h0000008e}  // Gets issues while busy
	};

	logic clk;
	logic rst_n;
	logic issue;
	exe_op_t op;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] result;
	logic result_valid;
	logic busy;
	logic [31:0] lfsr;
	row_t rows[$];

	execute_unit execute_unit_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Forty cycles per row plus reset
	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + 40 * N_ROWS));
		$display("Timeout: the run did not finish in time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	// Bound checker failures end the run at once
	always @(execute_unit_i.execute_unit_properties_i.fail_cnt) begin
		if (execute_unit_i.execute_unit_properties_i.fail_cnt != 0) begin
			$display("A bound assertion on the DUT ports failed");
			$display("Testbench failed");
			$fatal(1, "assertion failed");
		end
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
	endtask

	// Expected values from the RV32IM rules
	function automatic logic [31:0] ref_result(input exe_op_t o, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sq;
		logic signed [31:0] sr;
		sq = '1;  // Zero divisor
		sr = a;
		if (a == 32'h80000000 && b == '1) begin
			sq = a;
			sr = '0;
		end else if (b != '0) begin
			sq = $signed(a) / $signed(b);  // Truncates toward zero
			sr = $signed(a) % $signed(b);
		end
		case (o)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			OP_SRL:  return a >> b[4:0];
			OP_SRA:  return $signed(a) >>> b[4:0];
			OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
			OP_SLTU: return {31'b0, a < b};
			OP_DIV:  return sq;
			OP_REM:  return sr;
			OP_DIVU: return (b == '0) ? '1 : a / b;
			OP_REMU: return (b == '0) ? a : a % b;
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic run_row(input row_t row, input logic intrude);
		int cycles;
		int lat;
		lat = (row.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) ? 34 : 1;
		@(posedge clk);
		#2;
		issue = 1'b1;
		op = row.op;
		op_a = row.a;
		op_b = row.b;
		@(posedge clk);  // Issue edge
		#2;
		issue = 1'b0;
		cycles = 0;
		while (!result_valid && cycles < ROW_LIMIT) begin
			check_value("busy", {31'b0, busy}, {31'b0, lat == 34});  // High until capture
			@(posedge clk);
			#2;
			cycles++;
			if (intrude) begin
				issue = (cycles == 5) || (cycles == 6);  // Divider busy here
				op = (cycles == 5) ? OP_ADD : OP_DIV;
				op_a = ~row.a;  // Operands a wrong reload would pick up
				op_b = row.b + 1;
			end
		end
		if (!result_valid) begin
			$display("No result_valid within %0d cycles of the issue", ROW_LIMIT);
			$display("Testbench failed");
			$fatal(1, "missing result");
		end
		check_value("latency", cycles, lat);
		check_value("result", result, row.exp);
		@(posedge clk);
		#2;
		check_value("result_valid", {31'b0, result_valid}, 32'd0);  // No extra pulse
	endtask

	initial begin
		row_t row;
		logic [31:0] shift;
		rst_n = 1'b0;
		issue = 1'b0;
		op = OP_ADD;
		op_a = '0;
		op_b = '0;
		lfsr = 32'h67f5;
		for (int i = 0; i < N_FIXED; i++) begin
			rows.push_back(FIXED[i]);
		end
		// Random rows cycle through all fourteen ops
		for (int i = 0; i < N_RAND; i++) begin
			row.op = exe_op_t'(i % 14);
			take_bits(32, row.a);
			take_bits(32, row.b);
			take_bits(5, shift);
			if (row.op inside {OP_DIV, OP_REM}) begin
				row.b = $signed(row.b) >>> shift;  // Divisor keeps its sign
			end else if (row.op inside {OP_DIVU, OP_REMU}) begin
				row.b = row.b >> shift;  // Wider spread of quotients
			end
			row.exp = ref_result(row.op, row.a, row.b);
			rows.push_back(row);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		check_value("result", result, 32'd0);
		check_value("result_valid", {31'b0, result_valid}, 32'd0);
		check_value("busy", {31'b0, busy}, 32'd0);
		rst_n = 1'b1;
		foreach (rows[r]) begin
			run_row(rows[r], r == N_FIXED - 1);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== execute_unit.f ====
+incdir+include
src/exe_pkg.sv
src/div_ctrl_if.sv
src/div_fsm.sv
src/div_step_counter.sv
src/div_datapath.sv
src/alu.sv
src/result_stage.sv
src/execute_unit.sv
sim/execute_unit_properties.sv
sim/execute_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = execute_unit_tb
FILELIST = execute_unit.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
